/* lsu_top.f */
hdl/lsu_pkg.sv
hdl/store_queue.sv
hdl/load_queue.sv
hdl/data_mem.sv
hdl/lsu_top.sv
dv/lsu_top_assert.sv
dv/lsu_top_tb.sv

/* Makefile */
SRCS := $(shell cat lsu_top.f)

.PHONY: run clean

obj_dir/Vlsu_top_tb: lsu_top.f $(SRCS)
	verilator --binary --assert --top-module lsu_top_tb -f lsu_top.f

run: obj_dir/Vlsu_top_tb
	@out="$$(obj_dir/Vlsu_top_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir

/* dv/lsu_top_tb.sv */
`timescale 1ns/10ps

module lsu_top_tb;
    import lsu_pkg::*;

    typedef enum logic [3:0] {
        DISP_LD, DISP_ST, ISS_LD, ISS_ST, CMT_LD, CMT_ST, FLUSH, IDLE,
        CHK_STATUS, WAIT_RESP, NO_RESP
    } op_kind_t;

    // Flush rows carry mis_ld_idx in slot, the mask in addr[7:0] and mis_st_idx in exp[1:0]
    // Status rows compare exp[5:0] with {ld_ready, st_ready, lq_tail, sq_tail}
    typedef struct packed {
        op_kind_t   kind;
        q_idx_t     slot;
        rob_idx_t   rob;
        preg_t      rd;
        word_t      addr;
        logic [7:0] exp;
    } op_t;

    logic       clk = 1'b0;
    logic       rst;
    fu_sel_t    fu_sel;
    preg_t      dc_rd;
    rob_idx_t   dc_rob_idx;
    logic       decode_valid;
    logic       ld_issue;
    logic       st_issue;
    q_idx_t     ld_issue_idx;
    q_idx_t     st_issue_idx;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    logic       ld_commit;
    logic       st_commit;
    logic       mispredict;
    logic [7:0] flush_mask;
    q_idx_t     mis_ld_idx;
    q_idx_t     mis_st_idx;
    logic       ld_ready;
    logic       st_ready;
    q_idx_t     lq_tail;
    q_idx_t     sq_tail;
    logic       ld_resp_valid;
    rob_idx_t   ld_resp_rob_idx;
    preg_t      ld_resp_rd;
    word_t      ld_resp_data;

    // Reference model
    word_t      ref_mem   [256];
    word_t      st_addr_m [Q_DEPTH];
    word_t      st_data_m [Q_DEPTH];
    q_idx_t     st_head_m;
    word_t      ld_addr_m [8];
    preg_t      ld_rd_m   [8];
    logic [7:0] pending;
    logic [7:0] seen;
    logic [31:0] rng;
    int         errors;
    int         timeouts;
    op_t        ops [$];

    lsu_top u_lsu_top (.*);

    bind lsu_top lsu_top_assert u_lsu_top_assert (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic note_error(string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic add(op_kind_t kind, int slot, int rob, int rd, int addr, int exp);
        op_t op;
        op.kind = kind;
        op.slot = q_idx_t'(slot);
        op.rob  = rob_idx_t'(rob);
        op.rd   = preg_t'(rd);
        op.addr = word_t'(addr);
        op.exp  = 8'(exp);
        ops.push_back(op);
    endtask

    // Sampled at the edge before the DUT updates
    task automatic observe();
        word_t exp_data;
        if (!rst) begin
            if (ld_resp_valid) begin
                exp_data = ref_mem[ld_addr_m[ld_resp_rob_idx][9:2]];
                assert (pending[ld_resp_rob_idx])
                    else note_error($sformatf("unexpected response, rob %0d", ld_resp_rob_idx));
                assert (ld_resp_rd == ld_rd_m[ld_resp_rob_idx])
                    else note_error($sformatf("rob %0d rd %0d, expected %0d", ld_resp_rob_idx,
                                              ld_resp_rd, ld_rd_m[ld_resp_rob_idx]));
                assert (ld_resp_data === exp_data)
                    else note_error($sformatf("rob %0d data %h, expected %h", ld_resp_rob_idx,
                                              ld_resp_data, exp_data));
                pending[ld_resp_rob_idx] = 1'b0;
                seen[ld_resp_rob_idx]    = 1'b1;
            end
            // Store commit writes memory at this edge
            if (st_commit) begin
                ref_mem[st_addr_m[st_head_m][9:2]] = st_data_m[st_head_m];
                st_head_m = st_head_m + 1'b1;
            end
            if (mispredict) begin
                pending = pending & ~flush_mask;
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        observe();
    endtask

    task automatic apply(op_t op);
        int n;
        decode_valid <= 1'b0;
        ld_issue     <= 1'b0;
        st_issue     <= 1'b0;
        ld_commit    <= 1'b0;
        st_commit    <= 1'b0;
        mispredict   <= 1'b0;
        case (op.kind)
            DISP_LD, DISP_ST: begin
                decode_valid <= 1'b1;
                fu_sel       <= (op.kind == DISP_LD) ? FU_LOAD : FU_STORE;
                dc_rob_idx   <= op.rob;
                dc_rd        <= op.rd;
                if (op.kind == DISP_LD) begin
                    ld_rd_m[op.rob] = op.rd;
                end
            end
            ISS_LD: begin
                ld_issue     <= 1'b1;
                ld_issue_idx <= op.slot;
                rs1_data     <= op.addr - 32'h8;
                imm          <= 32'h8;
                ld_addr_m[op.rob] = op.addr;
                pending[op.rob]   = 1'b1;
                seen[op.rob]      = 1'b0;
            end
            ISS_ST: begin
                rng = xorshift(rng);
                st_issue     <= 1'b1;
                st_issue_idx <= op.slot;
                rs1_data     <= op.addr - 32'h8;
                imm          <= 32'h8;
                rs2_data     <= rng;
                st_addr_m[op.slot] = op.addr;
                st_data_m[op.slot] = rng;
            end
            CMT_LD: ld_commit <= 1'b1;
            CMT_ST: st_commit <= 1'b1;
            FLUSH: begin
                mispredict <= 1'b1;
                flush_mask <= op.addr[7:0];
                mis_ld_idx <= op.slot;
                mis_st_idx <= op.exp[1:0];
            end
            CHK_STATUS: begin
                tick();
                assert ({ld_ready, st_ready, lq_tail, sq_tail} == op.exp[5:0])
                    else note_error($sformatf("status %b, expected %b",
                                              {ld_ready, st_ready, lq_tail, sq_tail},
                                              op.exp[5:0]));
            end
            WAIT_RESP: begin
                n = 0;
                while (!seen[op.rob] && n < 20) begin
                    tick();
                    n++;
                end
                if (!seen[op.rob]) begin
                    timeouts++;
                    $display("No load response for rob %0d within 20 cycles", op.rob);
                end
            end
            NO_RESP: begin
                repeat (op.exp) begin
                    tick();
                    assert (!ld_resp_valid)
                        else note_error($sformatf("response for rob %0d too early",
                                                  ld_resp_rob_idx));
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        rst          = 1'b1;
        fu_sel       = '0;
        dc_rd        = '0;
        dc_rob_idx   = '0;
        decode_valid = 1'b0;
        ld_issue     = 1'b0;
        st_issue     = 1'b0;
        ld_issue_idx = '0;
        st_issue_idx = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        imm          = '0;
        ld_commit    = 1'b0;
        st_commit    = 1'b0;
        mispredict   = 1'b0;
        flush_mask   = '0;
        mis_ld_idx   = '0;
        mis_st_idx   = '0;
        st_head_m    = '0;
        pending      = '0;
        seen         = '0;
        rng          = 32'hf0d8;
        errors       = 0;
        timeouts     = 0;

        // ==================================================================
        // Stimulus table
        // ==================================================================
        add(CHK_STATUS, 0, 0, 0, 0, 6'b110000);
        add(NO_RESP,    0, 0, 0, 0, 4);
        // Store then load to the same address
        add(DISP_ST,    0, 0, 0, 'h10, 0);
        add(DISP_ST,    1, 1, 0, 'h20, 0);
        add(ISS_ST,     0, 0, 0, 'h10, 0);
        add(ISS_ST,     1, 1, 0, 'h20, 0);
        add(CMT_ST,     0, 0, 0, 0, 0);
        add(CMT_ST,     0, 0, 0, 0, 0);
        add(DISP_LD,    0, 2, 5, 0, 0);
        add(ISS_LD,     0, 2, 0, 'h10, 0);
        add(WAIT_RESP,  0, 2, 0, 0, 0);
        // Bypass of an older store to another address and wait on a match
        add(DISP_ST,    2, 3, 0, 0, 0);
        add(ISS_ST,     2, 3, 0, 'h10, 0);
        add(DISP_LD,    1, 4, 6, 0, 0);
        add(ISS_LD,     1, 4, 0, 'h20, 0);
        add(WAIT_RESP,  0, 4, 0, 0, 0);
        add(DISP_LD,    2, 5, 7, 0, 0);
        add(ISS_LD,     2, 5, 0, 'h10, 0);
        add(NO_RESP,    0, 0, 0, 0, 4);
        add(CMT_ST,     0, 0, 0, 0, 0);
        add(WAIT_RESP,  0, 5, 0, 0, 0);
        // Load behind an unissued store
        add(DISP_ST,    3, 6, 0, 0, 0);
        add(DISP_LD,    3, 7, 8, 0, 0);
        add(ISS_LD,     3, 7, 0, 'h20, 0);
        add(NO_RESP,    0, 0, 0, 0, 4);
        add(ISS_ST,     3, 6, 0, 'h30, 0);
        add(WAIT_RESP,  0, 7, 0, 0, 0);
        add(CMT_ST,     0, 0, 0, 0, 0);
        // Load queue full
        add(CHK_STATUS, 0, 0, 0, 0, 6'b010000);
        add(DISP_LD,    0, 0, 9, 0, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b010000);
        add(CMT_LD,     0, 0, 0, 0, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b110000);
        // Mispredict over a store and a granted load
        add(DISP_ST,    0, 1, 0, 0, 0);
        add(ISS_ST,     0, 1, 0, 'h20, 0);
        add(DISP_LD,    0, 2, 10, 0, 0);
        add(ISS_LD,     0, 2, 0, 'h30, 0);
        add(FLUSH,      0, 0, 0, 'h06, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b110000);
        add(NO_RESP,    0, 0, 0, 0, 5);
        add(DISP_LD,    0, 3, 11, 0, 0);
        add(ISS_LD,     0, 3, 0, 'h20, 0);
        add(WAIT_RESP,  0, 3, 0, 0, 0);
        // Store queue full
        add(DISP_ST,    0, 4, 0, 0, 0);
        add(DISP_ST,    1, 5, 0, 0, 0);
        add(DISP_ST,    2, 6, 0, 0, 0);
        add(DISP_ST,    3, 7, 0, 0, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b000100);
        add(DISP_ST,    0, 0, 0, 0, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b000100);
        add(ISS_ST,     0, 4, 0, 'h40, 0);
        add(CMT_ST,     0, 0, 0, 0, 0);
        add(CHK_STATUS, 0, 0, 0, 0, 6'b010100);
        add(IDLE,       0, 0, 0, 0, 0);

        repeat (3) tick();
        rst <= 1'b0;
        foreach (ops[i]) begin
            tick();
            apply(ops[i]);
        end
        tick();

        $display("Errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 errors, timeouts, u_lsu_top.u_lsu_top_assert.fail_count);
        if (errors == 0 && timeouts == 0 && u_lsu_top.u_lsu_top_assert.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dv/lsu_top_assert.sv */
`timescale 1ns/10ps

module lsu_top_assert (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_ready,
    input  logic                 st_ready,
    input  lsu_pkg::q_idx_t      lq_tail,
    input  lsu_pkg::q_idx_t      sq_tail,
    input  logic                 mispredict,
    input  logic [7:0]           flush_mask,
    input  logic                 ld_resp_valid,
    input  lsu_pkg::rob_idx_t    ld_resp_rob_idx
);

    // ROB indices flushed in the previous cycle
    logic [7:0] flushed;
    int         fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            flushed <= '0;
        end else begin
            flushed <= mispredict ? flush_mask : 8'h00;
        end
    end

    resp_low_after_reset: assert property (@(posedge clk) $past(rst) && !rst |-> !ld_resp_valid)
        else begin
            $error("load response valid right after reset");
            fail_count++;
        end

    lq_tail_held: assert property (@(posedge clk) disable iff (rst)
        !ld_ready && !mispredict |=> lq_tail == $past(lq_tail))
        else begin
            $error("load queue tail moved while full");
            fail_count++;
        end

    sq_tail_held: assert property (@(posedge clk) disable iff (rst)
        !st_ready && !mispredict |=> sq_tail == $past(sq_tail))
        else begin
            $error("store queue tail moved while full");
            fail_count++;
        end

    no_flushed_resp: assert property (@(posedge clk) disable iff (rst)
        ld_resp_valid |-> !flushed[ld_resp_rob_idx])
        else begin
            $error("response for a flushed load");
            fail_count++;
        end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/10ps

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    // Dispatch
    input  lsu_pkg::fu_sel_t     fu_sel,
    input  lsu_pkg::preg_t       dc_rd,
    input  lsu_pkg::rob_idx_t    dc_rob_idx,
    input  logic                 decode_valid,
    // Issue
    input  logic                 ld_issue,
    input  logic                 st_issue,
    input  lsu_pkg::q_idx_t      ld_issue_idx,
    input  lsu_pkg::q_idx_t      st_issue_idx,
    input  lsu_pkg::word_t       rs1_data,
    input  lsu_pkg::word_t       rs2_data,
    input  lsu_pkg::word_t       imm,
    // Commit
    input  logic                 ld_commit,
    input  logic                 st_commit,
    // Mispredict
    input  logic                 mispredict,
    input  logic [7:0]           flush_mask,
    input  lsu_pkg::q_idx_t      mis_ld_idx,
    input  lsu_pkg::q_idx_t      mis_st_idx,
    // Status
    output logic                 ld_ready,
    output logic                 st_ready,
    output lsu_pkg::q_idx_t      lq_tail,
    output lsu_pkg::q_idx_t      sq_tail,
    // Load response
    output logic                 ld_resp_valid,
    output lsu_pkg::rob_idx_t    ld_resp_rob_idx,
    output lsu_pkg::preg_t       ld_resp_rd,
    output lsu_pkg::word_t       ld_resp_data
);
    import lsu_pkg::*;

    // Store queue state seen by the loads
    q_idx_t             sq_head;
    logic [Q_DEPTH-1:0] sq_valid;
    logic [Q_DEPTH-1:0] sq_issued;
    word_t              sq_addr [Q_DEPTH];

    // Memory port
    word_t  sq_head_addr;
    word_t  sq_head_data;
    logic   ld_req;
    word_t  ld_req_addr;
    logic   ld_grant;

    load_queue u_load_queue (
        .clk             (clk),
        .rst             (rst),
        .decode_valid    (decode_valid),
        .fu_sel          (fu_sel),
        .dc_rd           (dc_rd),
        .dc_rob_idx      (dc_rob_idx),
        .ld_issue        (ld_issue),
        .ld_issue_idx    (ld_issue_idx),
        .rs1_data        (rs1_data),
        .imm             (imm),
        .ld_commit       (ld_commit),
        .mispredict      (mispredict),
        .flush_mask      (flush_mask),
        .mis_ld_idx      (mis_ld_idx),
        .sq_head         (sq_head),
        .sq_tail         (sq_tail),
        .sq_valid        (sq_valid),
        .sq_issued       (sq_issued),
        .sq_addr         (sq_addr),
        .ld_grant        (ld_grant),
        .ld_req          (ld_req),
        .ld_req_addr     (ld_req_addr),
        .ld_ready        (ld_ready),
        .lq_tail         (lq_tail),
        .ld_resp_valid   (ld_resp_valid),
        .ld_resp_rob_idx (ld_resp_rob_idx),
        .ld_resp_rd      (ld_resp_rd)
    );

    store_queue u_store_queue (
        .clk          (clk),
        .rst          (rst),
        .decode_valid (decode_valid),
        .fu_sel       (fu_sel),
        .dc_rob_idx   (dc_rob_idx),
        .st_issue     (st_issue),
        .st_issue_idx (st_issue_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .st_commit    (st_commit),
        .mispredict   (mispredict),
        .flush_mask   (flush_mask),
        .mis_st_idx   (mis_st_idx),
        .st_ready     (st_ready),
        .sq_head      (sq_head),
        .sq_tail      (sq_tail),
        .sq_valid     (sq_valid),
        .sq_issued    (sq_issued),
        .sq_addr      (sq_addr),
        .sq_head_addr (sq_head_addr),
        .sq_head_data (sq_head_data)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .clk          (clk),
        .ld_req       (ld_req),
        .ld_req_addr  (ld_req_addr),
        .ld_grant     (ld_grant),
        .rd_data      (ld_resp_data),
        .st_commit    (st_commit),
        .sq_head_addr (sq_head_addr),
        .sq_head_data (sq_head_data)
    );

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/10ps

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    // Load port
    input  logic              ld_req,
    input  lsu_pkg::word_t    ld_req_addr,
    output logic              ld_grant,
    output lsu_pkg::word_t    rd_data,
    // Committing store
    input  logic              st_commit,
    input  lsu_pkg::word_t    sq_head_addr,
    input  lsu_pkg::word_t    sq_head_data
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t              mem [MEM_WORDS];
    logic [IDX_W-1:0]   ld_word;
    logic [IDX_W-1:0]   st_word;

    // Word index without the byte offset
    assign ld_word = ld_req_addr[IDX_W+1:2];
    assign st_word = sq_head_addr[IDX_W+1:2];

    // Commit owns the single port in its cycle
    assign ld_grant = ld_req && !st_commit;

    always_ff @(posedge clk) begin
        if (st_commit) begin
            mem[st_word] <= sq_head_data;
        end else if (ld_req) begin
            rd_data <= mem[ld_word];
        end
    end

endmodule

/* hdl/load_queue.sv */
`timescale 1ns/10ps

module load_queue (
    input  logic                           clk,
    input  logic                           rst,
    // Dispatch
    input  logic                           decode_valid,
    input  lsu_pkg::fu_sel_t               fu_sel,
    input  lsu_pkg::preg_t                 dc_rd,
    input  lsu_pkg::rob_idx_t              dc_rob_idx,
    // Issue
    input  logic                           ld_issue,
    input  lsu_pkg::q_idx_t                ld_issue_idx,
    input  lsu_pkg::word_t                 rs1_data,
    input  lsu_pkg::word_t                 imm,
    // Commit and flush
    input  logic                           ld_commit,
    input  logic                           mispredict,
    input  logic [7:0]                     flush_mask,
    input  lsu_pkg::q_idx_t                mis_ld_idx,
    // Store queue state
    input  lsu_pkg::q_idx_t                sq_head,
    input  lsu_pkg::q_idx_t                sq_tail,
    input  logic [lsu_pkg::Q_DEPTH-1:0]    sq_valid,
    input  logic [lsu_pkg::Q_DEPTH-1:0]    sq_issued,
    input  lsu_pkg::word_t                 sq_addr [lsu_pkg::Q_DEPTH],
    // Memory
    input  logic                           ld_grant,
    output logic                           ld_req,
    output lsu_pkg::word_t                 ld_req_addr,
    // Status and response
    output logic                           ld_ready,
    output lsu_pkg::q_idx_t                lq_tail,
    output logic                           ld_resp_valid,
    output lsu_pkg::rob_idx_t              ld_resp_rob_idx,
    output lsu_pkg::preg_t                 ld_resp_rd
);
    import lsu_pkg::*;

    logic [Q_DEPTH-1:0] lq_valid;
    logic [Q_DEPTH-1:0] lq_issued;
    logic [Q_DEPTH-1:0] lq_done;
    // Store queue full at dispatch so all four stores are older
    logic [Q_DEPTH-1:0] lq_sq_all;
    rob_idx_t           lq_rob_idx [Q_DEPTH];
    preg_t              lq_rd      [Q_DEPTH];
    word_t              lq_addr    [Q_DEPTH];
    q_idx_t             lq_sq_tail [Q_DEPTH];
    q_idx_t             lq_head;

    logic [Q_DEPTH-1:0] age_mask [Q_DEPTH];
    logic [Q_DEPTH-1:0] blocker  [Q_DEPTH];
    logic [Q_DEPTH-1:0] can_req;
    q_idx_t             req_idx;
    q_idx_t             resp_idx;
    logic               ld_dispatch;
    logic               sq_full;

    assign ld_ready    = !(lq_head == lq_tail && lq_valid[lq_head]);
    assign ld_dispatch = decode_valid && (fu_sel == FU_LOAD) && ld_ready && !mispredict;
    assign sq_full     = (sq_head == sq_tail) && sq_valid[sq_head];

    // ==================================================================
    // Ordering against older stores
    // ==================================================================

    always_comb begin
        for (int i = 0; i < Q_DEPTH; i++) begin
            for (int j = 0; j < Q_DEPTH; j++) begin
                if (lq_sq_tail[i] == sq_head) begin
                    age_mask[i][j] = lq_sq_all[i];
                end else if (lq_sq_tail[i] > sq_head) begin
                    age_mask[i][j] = (q_idx_t'(j) >= sq_head) && (q_idx_t'(j) < lq_sq_tail[i]);
                end else begin
                    // Window wraps past the last slot
                    age_mask[i][j] = (q_idx_t'(j) >= sq_head) || (q_idx_t'(j) < lq_sq_tail[i]);
                end
                blocker[i][j] = sq_valid[j] && (!sq_issued[j] || sq_addr[j] == lq_addr[i]);
            end
            can_req[i] = lq_valid[i] && lq_issued[i] && !lq_done[i]
                         && ((age_mask[i] & blocker[i]) == '0);
        end
    end

    // Oldest eligible load counted from the head
    always_comb begin
        q_idx_t slot;
        ld_req  = 1'b0;
        req_idx = '0;
        for (int k = 0; k < Q_DEPTH; k++) begin
            slot = lq_head + q_idx_t'(k);
            if (!ld_req && can_req[slot]) begin
                ld_req  = 1'b1;
                req_idx = slot;
            end
        end
    end

    assign ld_req_addr = lq_addr[req_idx];

    // ==================================================================
    // Entry control
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            lq_valid  <= '0;
            lq_issued <= '0;
            lq_done   <= '0;
            lq_sq_all <= '0;
            lq_head   <= '0;
            lq_tail   <= '0;
        end else begin
            for (int i = 0; i < Q_DEPTH; i++) begin
                // Once the store head moves the tail window is unambiguous
                if (lq_sq_all[i] && lq_sq_tail[i] != sq_head) begin
                    lq_sq_all[i] <= 1'b0;
                end
                if (ld_dispatch && q_idx_t'(i) == lq_tail) begin
                    lq_valid[i]  <= 1'b1;
                    lq_issued[i] <= 1'b0;
                    lq_done[i]   <= 1'b0;
                    lq_sq_all[i] <= sq_full;
                end
                if (ld_issue && q_idx_t'(i) == ld_issue_idx) begin
                    lq_issued[i] <= 1'b1;
                end
                if (ld_grant && q_idx_t'(i) == req_idx) begin
                    lq_done[i] <= 1'b1;
                end
                if ((ld_commit && q_idx_t'(i) == lq_head)
                    || (mispredict && lq_valid[i] && flush_mask[lq_rob_idx[i]])) begin
                    lq_valid[i]  <= 1'b0;
                    lq_issued[i] <= 1'b0;
                    lq_done[i]   <= 1'b0;
                end
            end

            if (mispredict) begin
                lq_tail <= mis_ld_idx;
            end else if (ld_dispatch) begin
                lq_tail <= lq_tail + 1'b1;
            end

            if (ld_commit) begin
                lq_head <= lq_head + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (ld_dispatch) begin
            lq_rob_idx[lq_tail] <= dc_rob_idx;
            lq_rd[lq_tail]      <= dc_rd;
            lq_sq_tail[lq_tail] <= sq_tail;
        end
        if (ld_issue) begin
            lq_addr[ld_issue_idx] <= rs1_data + imm;
        end
    end

    // ==================================================================
    // Response one cycle after the grant
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            ld_resp_valid <= 1'b0;
            resp_idx      <= '0;
        end else begin
            // A load flushed at its grant edge never answers
            ld_resp_valid <= ld_grant && !(mispredict && flush_mask[lq_rob_idx[req_idx]]);
            resp_idx      <= req_idx;
        end
    end

    assign ld_resp_rob_idx = lq_rob_idx[resp_idx];
    assign ld_resp_rd      = lq_rd[resp_idx];

endmodule

/* hdl/store_queue.sv */
`timescale 1ns/10ps

module store_queue (
    input  logic                           clk,
    input  logic                           rst,
    // Dispatch
    input  logic                           decode_valid,
    input  lsu_pkg::fu_sel_t               fu_sel,
    input  lsu_pkg::rob_idx_t              dc_rob_idx,
    // Issue
    input  logic                           st_issue,
    input  lsu_pkg::q_idx_t                st_issue_idx,
    input  lsu_pkg::word_t                 rs1_data,
    input  lsu_pkg::word_t                 rs2_data,
    input  lsu_pkg::word_t                 imm,
    // Commit and flush
    input  logic                           st_commit,
    input  logic                           mispredict,
    input  logic [7:0]                     flush_mask,
    input  lsu_pkg::q_idx_t                mis_st_idx,
    // Status
    output logic                           st_ready,
    output lsu_pkg::q_idx_t                sq_head,
    output lsu_pkg::q_idx_t                sq_tail,
    output logic [lsu_pkg::Q_DEPTH-1:0]    sq_valid,
    output logic [lsu_pkg::Q_DEPTH-1:0]    sq_issued,
    output lsu_pkg::word_t                 sq_addr [lsu_pkg::Q_DEPTH],
    // Head store towards memory
    output lsu_pkg::word_t                 sq_head_addr,
    output lsu_pkg::word_t                 sq_head_data
);
    import lsu_pkg::*;

    rob_idx_t   sq_rob_idx [Q_DEPTH];
    word_t      sq_data    [Q_DEPTH];
    logic       st_dispatch;

    assign st_ready    = !(sq_head == sq_tail && sq_valid[sq_head]);
    // Wrong-path dispatch is dropped while the tail rewinds
    assign st_dispatch = decode_valid && (fu_sel == FU_STORE) && st_ready && !mispredict;

    assign sq_head_addr = sq_addr[sq_head];
    assign sq_head_data = sq_data[sq_head];

    // ==================================================================
    // Entry control
    // ==================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            sq_valid  <= '0;
            sq_issued <= '0;
            sq_head   <= '0;
            sq_tail   <= '0;
        end else begin
            for (int i = 0; i < Q_DEPTH; i++) begin
                if (st_dispatch && q_idx_t'(i) == sq_tail) begin
                    sq_valid[i]  <= 1'b1;
                    sq_issued[i] <= 1'b0;
                end
                if (st_issue && q_idx_t'(i) == st_issue_idx) begin
                    sq_issued[i] <= 1'b1;
                end
                if (st_commit && q_idx_t'(i) == sq_head) begin
                    sq_valid[i]  <= 1'b0;
                    sq_issued[i] <= 1'b0;
                end
                // Flush has the last word on a slot
                if (mispredict && sq_valid[i] && flush_mask[sq_rob_idx[i]]) begin
                    sq_valid[i]  <= 1'b0;
                    sq_issued[i] <= 1'b0;
                end
            end

            if (mispredict) begin
                sq_tail <= mis_st_idx;
            end else if (st_dispatch) begin
                sq_tail <= sq_tail + 1'b1;
            end

            if (st_commit) begin
                sq_head <= sq_head + 1'b1;
            end
        end
    end

    // ==================================================================
    // Entry payload
    // ==================================================================

    always_ff @(posedge clk) begin
        if (st_dispatch) begin
            sq_rob_idx[sq_tail] <= dc_rob_idx;
        end
        if (st_issue) begin
            sq_addr[st_issue_idx] <= rs1_data + imm;
            sq_data[st_issue_idx] <= rs2_data;
        end
    end

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // ==================================================================
    // Queue geometry
    // ==================================================================

    // Power-of-two depth that the heads and tails wrap on
    localparam int Q_DEPTH = 4;

    typedef logic [$clog2(Q_DEPTH)-1:0] q_idx_t;

    // ==================================================================
    // Datapath and tag widths
    // ==================================================================

    // Data word or byte address
    typedef logic [31:0] word_t;

    // Reorder buffer slot
    typedef logic [2:0] rob_idx_t;

    // Physical destination register
    typedef logic [6:0] preg_t;

    // ==================================================================
    // Functional unit select from decode
    // ==================================================================

    typedef logic [2:0] fu_sel_t;

    localparam fu_sel_t FU_LOAD  = 3'd6;
    localparam fu_sel_t FU_STORE = 3'd7;

endpackage
